// ==== project.f ====
common/tsc_pkg.sv
common/pipe_if.sv
issue/issue_decode.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/writeback_stage.sv
rtl/tsc_backend.sv
sim/tb_tsc_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it.
# The simulator's exit status is the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -sv \
    -f project.f \
    --top-module tb_tsc_backend \
    -Mdir obj_dir

./obj_dir/Vtb_tsc_backend

// ==== sim/tb_tsc_backend.sv ====
`timescale 1ns/1ps

module tb_tsc_backend;
    import tsc_pkg::*;

    localparam int RST_CYCLES  = 5;
    localparam int N_DIRECT    = 30;
    localparam int N_RAND_A    = 120;
    localparam int N_RAND_B    = 80;
    localparam int N_MIDRUN    = 7;    // Three in flight then four WWD.
    localparam int N_AFTER_HLT = 7;
    localparam int N_DRAIN     = 4;
    localparam int ISSUE_CYCLES = 2 * RST_CYCLES + N_DIRECT + N_RAND_A + N_RAND_B
                                + N_MIDRUN + N_AFTER_HLT + 5 * N_DRAIN;
    localparam int MAX_CYCLES  = ISSUE_CYCLES + 50;

    logic        clk = 1'b0;
    logic        reset_n;
    logic        instr_valid;
    instr_word_t instr;
    word_t       output_port;
    logic        output_valid;
    logic        halted;
    word_t       num_inst;

    logic [31:0] seed;
    int          cycle = 0;
    word_t       m_regs [NUM_REGS];
    word_t       m_mem [DMEM_DEPTH];
    int          pend_cyc [$];
    reg_idx_t    pend_idx [$];
    word_t       pend_data [$];
    word_t       exp_out [$];
    int          exp_cyc [$];
    int          m_count;
    logic        m_halt_seen;
    int          halt_cyc;

    tsc_backend #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) tsc_backend_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .output_port  (output_port),
        .output_valid (output_valid),
        .halted       (halted),
        .num_inst     (num_inst)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            stop_on_failure($sformatf("timeout, run did not end within %0d cycles", MAX_CYCLES));
        end
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                                      name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("CHECK FAILED %s expected %b actual %b",
                                      name, expected, actual));
        end
    endtask

    function automatic logic [15:0] rand_word();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:16];
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand_word()) % n;
    endfunction

    function automatic instr_word_t wwd_of(input reg_idx_t r);
        return {4'hF, r, 4'h0, 6'd28};
    endfunction

    // r0 is never written, so memory ops based on it stay in range.
    function automatic instr_word_t random_instr();
        int          kind;
        logic [15:0] r;
        reg_idx_t    dst;
        kind = rand_below(9);
        r    = rand_word();
        dst  = 2'(1 + rand_below(3));
        case (kind)
            0, 1, 2, 3: return {4'hF, r[1:0], r[3:2], dst, 6'(kind)};
            4:          return {4'd4, r[1:0], dst, r[15:8]};
            5:          return {4'd6, r[1:0], dst, r[15:8]};
            6:          return {4'd7, 2'd0, dst, 4'h0, r[11:8]};
            7:          return {4'd8, 2'd0, r[3:2], 4'h0, r[11:8]};
            default:    return wwd_of(r[1:0]);
        endcase
    endfunction

    function automatic void model_reset();
        for (int k = 0; k < NUM_REGS; k++) begin
            m_regs[k] = '0;
        end
        for (int k = 0; k < DMEM_DEPTH; k++) begin
            m_mem[k] = '0;
        end
        pend_cyc.delete();
        pend_idx.delete();
        pend_data.delete();
        exp_out.delete();
        exp_cyc.delete();
        m_count     = 0;
        m_halt_seen = 1'b0;
        halt_cyc    = 0;
    endfunction

    function automatic void queue_write(input reg_idx_t idx, input word_t data, input int t);
        pend_cyc.push_back(t);
        pend_idx.push_back(idx);
        pend_data.push_back(data);
    endfunction

    // Reference model step for the word sampled at edge t.
    function automatic void model_step(input instr_word_t w, input int t);
        logic [15:0] bits;
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        word_t       rs_v;
        word_t       rt_v;
        word_t       imm_s;
        word_t       addr;
        logic        legal;
        bits = w;
        if (m_halt_seen) return;
        while (pend_cyc.size() > 0 && pend_cyc[0] + 3 <= t) begin
            m_regs[pend_idx[0]] = pend_data[0];   // Visible three samples later.
            pend_cyc.delete(0);
            pend_idx.delete(0);
            pend_data.delete(0);
        end
        rs    = bits[11:10];
        rt    = bits[9:8];
        rd    = bits[7:6];
        rs_v  = m_regs[rs];
        rt_v  = m_regs[rt];
        imm_s = {{8{bits[7]}}, bits[7:0]};
        addr  = rs_v + imm_s;
        legal = 1'b1;
        case (bits[15:12])
            4'hF: begin
                case (bits[5:0])
                    6'd0:  queue_write(rd, rs_v + rt_v, t);
                    6'd1:  queue_write(rd, rs_v - rt_v, t);
                    6'd2:  queue_write(rd, rs_v & rt_v, t);
                    6'd3:  queue_write(rd, rs_v | rt_v, t);
                    6'd28: begin
                        exp_out.push_back(rs_v);
                        exp_cyc.push_back(t + 3);
                    end
                    6'd29: begin
                        m_halt_seen = 1'b1;
                        halt_cyc    = t;
                    end
                    default: legal = 1'b0;
                endcase
            end
            4'd4:    queue_write(rt, rs_v + imm_s, t);
            4'd6:    queue_write(rt, {bits[7:0], 8'h00}, t);
            4'd7:    queue_write(rt, m_mem[addr[7:0]], t);
            4'd8:    m_mem[addr[7:0]] = rt_v;
            default: legal = 1'b0;
        endcase
        if (legal) m_count++;
    endfunction

    task automatic issue_word(input instr_word_t w);
        instr_valid = 1'b1;
        instr       = w;
        @(posedge clk);
        model_step(w, cycle + 1);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            instr_valid = 1'b0;
            instr       = rand_word();   // Junk while the strobe is low.
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_and_count(input string name);
        idle_cycles(N_DRAIN);
        check_word(name, 16'(m_count), num_inst);
    endtask

    task automatic apply_reset();
        reset_n     = 1'b1;
        instr_valid = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        model_reset();
        #1;
        reset_n = 1'b0;
        check_flag("output_valid after reset", 1'b0, output_valid);
        check_flag("halted after reset", 1'b0, halted);
        check_word("num_inst after reset", 16'h0000, num_inst);
        check_word("output_port after reset", 16'h0000, output_port);
    endtask

    task automatic run_random(input int steps);
        for (int k = 0; k < steps; k++) begin
            if (rand_below(4) == 0) begin
                idle_cycles(1);
            end else begin
                issue_word(random_instr());
            end
        end
    endtask

    task automatic run_directed();
        issue_word({4'd6, 2'd0, 2'd1, 8'h12});          // LHI r1.
        repeat (3) issue_word(wwd_of(2'd1));            // Old, old, new.
        issue_word({4'd4, 2'd1, 2'd2, 8'hFD});          // ADI r2 = r1 - 3.
        issue_word({4'hF, 2'd1, 2'd2, 2'd3, 6'd0});     // Reads r2 too early.
        idle_cycles(2);
        issue_word(wwd_of(2'd2));
        issue_word(wwd_of(2'd3));
        issue_word({4'd8, 2'd0, 2'd1, 8'h05});          // SWD r1 to [5].
        issue_word({4'd7, 2'd0, 2'd2, 8'h05});
        issue_word({4'd7, 2'd0, 2'd3, 8'h06});          // Unwritten address.
        issue_word({4'hF, 2'd3, 2'd2, 2'd1, 6'd1});
        idle_cycles(2);
        issue_word(wwd_of(2'd2));
        issue_word(wwd_of(2'd3));
        issue_word(wwd_of(2'd1));
        issue_word({4'hF, 2'd2, 2'd3, 2'd1, 6'd3});
        issue_word({4'hF, 2'd1, 2'd2, 2'd3, 6'd2});
        idle_cycles(3);
        issue_word(wwd_of(2'd1));
        issue_word(wwd_of(2'd3));
    endtask

    always @(negedge clk) begin
        if (!reset_n) begin
            if (output_valid) begin
                if (exp_out.size() == 0) begin
                    stop_on_failure("output_valid pulsed with no WWD in flight");
                end else begin
                    check_word("wwd output_port", exp_out[0], output_port);
                    check_flag("wwd three edges after issue", 1'b1, cycle == exp_cyc[0]);
                    exp_out.delete(0);
                    exp_cyc.delete(0);
                end
            end else if (exp_cyc.size() > 0 && cycle >= exp_cyc[0]) begin
                stop_on_failure("output_valid missing for a WWD");
            end
            check_flag("halted", m_halt_seen && (cycle >= halt_cyc + 3), halted);
        end
    end

    initial begin
        seed        = 32'h5eda_a6b3;
        reset_n     = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        model_reset();
        apply_reset();
        run_directed();
        drain_and_count("num_inst after directed");
        run_random(N_RAND_A);
        drain_and_count("num_inst after random run");
        repeat (3) issue_word(random_instr());
        apply_reset();                                  // Hits work in flight.
        for (int k = 0; k < NUM_REGS; k++) begin
            issue_word(wwd_of(2'(k)));
        end
        drain_and_count("num_inst after mid-run reset");
        run_random(N_RAND_B);
        drain_and_count("num_inst before HLT");
        issue_word({4'hF, 2'd0, 2'd0, 2'd0, 6'd29});
        repeat (N_AFTER_HLT - 1) issue_word(random_instr());
        drain_and_count("num_inst after HLT");
        check_flag("halted after HLT", 1'b1, halted);
        if (exp_out.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_on_failure("a WWD result never reached output_port");
        end
    end

endmodule

// ==== rtl/tsc_backend.sv ====
`timescale 1ns/1ps

module tsc_backend
    import tsc_pkg::*;
#(
    parameter int DMEM_DEPTH = tsc_pkg::DMEM_DEPTH
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        instr_valid,
    input  instr_word_t instr,
    output word_t       output_port,
    output logic        output_valid,
    output logic        halted,
    output word_t       num_inst
);

    logic     wb_en;
    reg_idx_t wb_idx;
    word_t    wb_data;

    pipe_if idex ();
    pipe_if exmem ();
    pipe_if memwb ();

    issue_decode issue_decode_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_en       (wb_en),
        .wb_idx      (wb_idx),
        .wb_data     (wb_data),
        .idex        (idex.source)
    );

    execute_stage execute_stage_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .idex    (idex.sink),
        .exmem   (exmem.source)
    );

    memory_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) memory_stage_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .exmem   (exmem.sink),
        .memwb   (memwb.source)
    );

    writeback_stage writeback_stage_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .memwb        (memwb.sink),
        .wb_en        (wb_en),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .halted       (halted),
        .num_inst     (num_inst)
    );

endmodule

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage
    import tsc_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    pipe_if.sink     memwb,
    output logic     wb_en,
    output reg_idx_t wb_idx,
    output word_t    wb_data,
    output word_t    output_port,
    output logic     output_valid,
    output logic     halted,
    output word_t    num_inst
);

    logic retire;
    logic wwd_retire;

    assign retire     = memwb.valid;
    assign wwd_retire = memwb.valid && memwb.is_wwd;

    // Register file takes this at E3.
    assign wb_en   = memwb.valid && memwb.reg_write;
    assign wb_idx  = memwb.rd;
    assign wb_data = memwb.result;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            output_port  <= '0;
            output_valid <= 1'b0;
        end else begin
            output_valid <= wwd_retire;   // One-cycle pulse.
            if (wwd_retire) begin
                output_port <= memwb.result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst <= '0;
        end else if (retire) begin
            num_inst <= num_inst + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halted <= 1'b0;
        end else if (retire && memwb.is_halt) begin
            halted <= 1'b1;
        end
    end

    // Issue stops after HLT, so nothing may follow it here.
    a_no_retire_after_halt: assert property (
        @(posedge clk) disable iff (reset_n)
        halted |-> !memwb.valid
    );

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage
    import tsc_pkg::*;
#(
    parameter int DMEM_DEPTH = tsc_pkg::DMEM_DEPTH
) (
    input  logic   clk,
    input  logic   reset_n,
    pipe_if.sink   exmem,
    pipe_if.source memwb
);

    localparam int AW = $clog2(DMEM_DEPTH);

    word_t          mem [DMEM_DEPTH];
    logic [AW-1:0]  addr;
    word_t          load_data;

    assign addr      = exmem.result[AW-1:0];
    assign load_data = mem[addr];      // Captured into memwb at E2.

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int k = 0; k < DMEM_DEPTH; k++) begin
                mem[k] <= '0;
            end
        end else if (exmem.valid && exmem.mem_write) begin
            mem[addr] <= exmem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            memwb.valid      <= 1'b0;
            memwb.reg_write  <= 1'b0;
            memwb.mem_to_reg <= 1'b0;
            memwb.mem_read   <= 1'b0;
            memwb.mem_write  <= 1'b0;
            memwb.is_wwd     <= 1'b0;
            memwb.is_halt    <= 1'b0;
            memwb.alu_op     <= ALU_ADD;
        end else begin
            memwb.valid      <= exmem.valid;
            memwb.reg_write  <= exmem.reg_write;
            memwb.mem_to_reg <= exmem.mem_to_reg;
            memwb.mem_read   <= exmem.mem_read;
            memwb.mem_write  <= exmem.mem_write;
            memwb.is_wwd     <= exmem.is_wwd;
            memwb.is_halt    <= exmem.is_halt;
            memwb.alu_op     <= exmem.alu_op;
        end
    end

    always_ff @(posedge clk) begin
        memwb.rd         <= exmem.rd;
        memwb.a          <= exmem.a;
        memwb.b          <= exmem.b;
        memwb.store_data <= exmem.store_data;
        memwb.result     <= exmem.mem_to_reg ? load_data : exmem.result;
    end

    // Address computed in execute must fit the memory.
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (reset_n)
        (exmem.valid && (exmem.mem_read || exmem.mem_write))
            |-> ((exmem.result >> AW) == '0)
    );

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import tsc_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    pipe_if.sink   idex,
    pipe_if.source exmem
);

    word_t alu_y;

    // Memory address is rs plus imm through the adder.
    always_comb begin
        case (idex.alu_op)
            ALU_ADD:    alu_y = idex.a + idex.b;
            ALU_SUB:    alu_y = idex.a - idex.b;
            ALU_AND:    alu_y = idex.a & idex.b;
            ALU_OR:     alu_y = idex.a | idex.b;
            ALU_PASS_B: alu_y = idex.b;
            ALU_PASS_A: alu_y = idex.a;
            default:    alu_y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            exmem.valid      <= 1'b0;
            exmem.reg_write  <= 1'b0;
            exmem.mem_to_reg <= 1'b0;
            exmem.mem_read   <= 1'b0;
            exmem.mem_write  <= 1'b0;
            exmem.is_wwd     <= 1'b0;
            exmem.is_halt    <= 1'b0;
            exmem.alu_op     <= ALU_ADD;
        end else begin
            exmem.valid      <= idex.valid;
            exmem.reg_write  <= idex.reg_write;
            exmem.mem_to_reg <= idex.mem_to_reg;
            exmem.mem_read   <= idex.mem_read;
            exmem.mem_write  <= idex.mem_write;
            exmem.is_wwd     <= idex.is_wwd;
            exmem.is_halt    <= idex.is_halt;
            exmem.alu_op     <= idex.alu_op;
        end
    end

    always_ff @(posedge clk) begin
        exmem.rd         <= idex.rd;
        exmem.a          <= idex.a;
        exmem.b          <= idex.b;
        exmem.store_data <= idex.store_data;   // rt value for SWD.
        exmem.result     <= alu_y;
    end

    a_one_mem_op: assert property (
        @(posedge clk) disable iff (reset_n)
        idex.valid |-> !(idex.mem_read && idex.mem_write)
    );

endmodule

// ==== issue/issue_decode.sv ====
`timescale 1ns/1ps

module issue_decode
    import tsc_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        instr_valid,
    input  instr_word_t instr,
    input  logic        wb_en,
    input  reg_idx_t    wb_idx,
    input  word_t       wb_data,
    pipe_if.source      idex
);

    word_t    regs [NUM_REGS];
    logic     halt_seen;
    logic     accept;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm_sext;
    logic     dec_legal;
    reg_idx_t dec_rd;
    logic     dec_reg_write;
    logic     dec_mem_read;
    logic     dec_mem_write;
    logic     dec_is_wwd;
    logic     dec_is_halt;
    alu_op_t  dec_alu_op;
    word_t    dec_b;

    assign accept = instr_valid && !halt_seen;

    // Write-first bypass.
    assign rs_val = (wb_en && wb_idx == instr.r.rs) ? wb_data : regs[instr.r.rs];
    assign rt_val = (wb_en && wb_idx == instr.r.rt) ? wb_data : regs[instr.r.rt];

    assign imm_sext = {{8{instr.i.imm[7]}}, instr.i.imm};

    always_comb begin
        dec_legal     = 1'b1;
        dec_rd        = instr.i.rt;    // I type writes rt.
        dec_reg_write = 1'b0;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_is_wwd    = 1'b0;
        dec_is_halt   = 1'b0;
        dec_alu_op    = ALU_ADD;
        dec_b         = imm_sext;
        case (instr.r.opcode)
            OP_ALU: begin
                dec_rd = instr.r.rd;
                dec_b  = rt_val;
                case (instr.r.func)
                    FN_ADD: begin
                        dec_reg_write = 1'b1;
                        dec_alu_op    = ALU_ADD;
                    end
                    FN_SUB: begin
                        dec_reg_write = 1'b1;
                        dec_alu_op    = ALU_SUB;
                    end
                    FN_AND: begin
                        dec_reg_write = 1'b1;
                        dec_alu_op    = ALU_AND;
                    end
                    FN_ORR: begin
                        dec_reg_write = 1'b1;
                        dec_alu_op    = ALU_OR;
                    end
                    FN_WWD: begin
                        dec_is_wwd = 1'b1;
                        dec_alu_op = ALU_PASS_A;
                    end
                    FN_HLT: dec_is_halt = 1'b1;
                    default: dec_legal = 1'b0;
                endcase
            end
            OP_ADI: dec_reg_write = 1'b1;
            OP_LHI: begin
                dec_reg_write = 1'b1;
                dec_alu_op    = ALU_PASS_B;
                dec_b         = {instr.i.imm, 8'h00};
            end
            OP_LWD: begin
                dec_reg_write = 1'b1;
                dec_mem_read  = 1'b1;
            end
            OP_SWD: dec_mem_write = 1'b1;
            default: dec_legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_seen       <= 1'b0;
            idex.valid      <= 1'b0;
            idex.reg_write  <= 1'b0;
            idex.mem_to_reg <= 1'b0;
            idex.mem_read   <= 1'b0;
            idex.mem_write  <= 1'b0;
            idex.is_wwd     <= 1'b0;
            idex.is_halt    <= 1'b0;
            idex.alu_op     <= ALU_ADD;
        end else begin
            halt_seen       <= halt_seen || (accept && dec_legal && dec_is_halt);
            idex.valid      <= accept && dec_legal;
            idex.reg_write  <= dec_reg_write;
            idex.mem_to_reg <= dec_mem_read;
            idex.mem_read   <= dec_mem_read;
            idex.mem_write  <= dec_mem_write;
            idex.is_wwd     <= dec_is_wwd;
            idex.is_halt    <= dec_is_halt;
            idex.alu_op     <= dec_alu_op;
        end
    end

    always_ff @(posedge clk) begin
        idex.rd         <= dec_rd;
        idex.a          <= rs_val;
        idex.b          <= dec_b;
        idex.store_data <= rt_val;
    end

    assign idex.result = '0;           // Filled by execute.

    // Unknown words decode to no work at all.
    a_illegal_dropped: assert property (
        @(posedge clk) disable iff (reset_n)
        idex.valid |-> $onehot({idex.reg_write, idex.mem_write, idex.is_wwd, idex.is_halt})
    );

endmodule

// ==== common/pipe_if.sv ====
`timescale 1ns/1ps

interface pipe_if
    import tsc_pkg::*;
();

    logic     valid;
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_to_reg;
    logic     mem_read;
    logic     mem_write;
    logic     is_wwd;
    logic     is_halt;
    alu_op_t  alu_op;
    word_t    a;
    word_t    b;
    word_t    store_data;
    word_t    result;          // ALU result, or load data after memory.

    modport source (
        output valid, rd,
        output reg_write, mem_to_reg, mem_read, mem_write,
        output is_wwd, is_halt,
        output alu_op,
        output a, b, store_data,
        output result
    );

    modport sink (
        input valid, rd,
        input reg_write, mem_to_reg, mem_read, mem_write,
        input is_wwd, is_halt,
        input alu_op,
        input a, b, store_data,
        input result
    );

endinterface

// ==== common/tsc_pkg.sv ====
package tsc_pkg;

    localparam int NUM_REGS   = 4;
    localparam int DMEM_DEPTH = 256;   // Address uses the low 8 bits.

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADI = 4'd4,
        OP_LHI = 4'd6,
        OP_LWD = 4'd7,
        OP_SWD = 4'd8,
        OP_ALU = 4'd15                 // R type.
    } opcode_t;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B,                    // LHI.
        ALU_PASS_A                     // WWD.
    } alu_op_t;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        func_t    func;
    } r_format_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [7:0] imm;
    } i_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_word_t;

endpackage
